// File: common/opq_defines.svh
`ifndef OPQ_DEFINES_SVH
`define OPQ_DEFINES_SVH

// Width of the operand, the accumulator and the result
`define OPQ_DATA_W 8

// Occupancy at which the queue reports full
// The FIFO count is four bits wide, so a queue of 16 entries only ever holds 15
`define OPQ_FULL_LEVEL 4'd15

// Occupancy width, set by the 16-entry FIFO
`define OPQ_CNT_W 4

`endif

// File: common/opq_pkg.sv
package opq_pkg;

	// ========================================================================
	// Opcodes
	// ========================================================================

	// Operations applied by the executor to its accumulator
	// The encoding fits the 3-bit opcode FIFO exactly, so every code is used
	typedef enum logic [2:0] {
		OP_NOP  = 3'd0,
		OP_LOAD = 3'd1,
		OP_ADD  = 3'd2,
		OP_SUB  = 3'd3,
		OP_AND  = 3'd4,
		OP_OR   = 3'd5,
		OP_XOR  = 3'd6,
		OP_NEG  = 3'd7
	} op_e;

	// ========================================================================
	// Executor states
	// ========================================================================

	// ST_WAIT gives the registered FIFO output one cycle to follow the read pointer
	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_WAIT = 2'd1,
		ST_EXEC = 2'd2
	} exec_state_e;

endpackage

// File: compile.f
+incdir+common
common/opq_pkg.sv
hdl/opq_fifo.sv
exec/opq_exec.sv
hdl/opq_top.sv
tb/opq_tb.sv

// File: exec/opq_exec.sv
`include "opq_defines.svh"

module opq_exec (
	input  logic                   rst,
	input  logic                   clk,
	input  logic                   push,
	input  logic [3:0]             occupancy,
	input  opq_pkg::op_e           op,
	input  logic [`OPQ_DATA_W-1:0] data,
	output logic                   pop,
	output logic                   res_valid,
	output logic [`OPQ_DATA_W-1:0] res_data,
	output opq_pkg::op_e           res_op
);

	import opq_pkg::*;

	// ========================================================================
	// ALU
	// ========================================================================

	// One operation on the accumulator
	// ADD, SUB and NEG wrap at the data width
	function automatic logic [`OPQ_DATA_W-1:0] alu(
		input op_e                    f_op,
		input logic [`OPQ_DATA_W-1:0] f_acc,
		input logic [`OPQ_DATA_W-1:0] f_data
	);
		logic [`OPQ_DATA_W-1:0] r;
		case (f_op)
			OP_LOAD: r = f_data;
			OP_ADD:  r = f_acc + f_data;
			OP_SUB:  r = f_acc - f_data;
			OP_AND:  r = f_acc & f_data;
			OP_OR:   r = f_acc | f_data;
			OP_XOR:  r = f_acc ^ f_data;
			// Two's complement of the accumulator, the operand is ignored
			OP_NEG:  r = ~f_acc + 1'b1;
			// NOP and anything else keep the accumulator
			default: r = f_acc;
		endcase
		return r;
	endfunction

	exec_state_e            state;
	exec_state_e            state_nxt;
	logic [`OPQ_DATA_W-1:0] acc;
	logic [`OPQ_DATA_W-1:0] acc_nxt;

	// New accumulator value for the entry at the head of the queue
	// Only meaningful in ST_EXEC, where the FIFO output has settled
	always_comb begin
		acc_nxt = alu(op, acc, data);
	end

	// ========================================================================
	// State machine
	// ========================================================================

	// Idle waits for work, wait covers the FIFO output register, exec retires one entry
	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				if (occupancy != 4'd0) begin
					state_nxt = ST_WAIT;
				end
			end
			// Exactly one cycle, the head entry is on dout after this
			ST_WAIT: state_nxt = ST_EXEC;
			ST_EXEC: begin
				// A push in this cycle holds off the pop, so the write is not lost
				if (!push) begin
					state_nxt = ST_IDLE;
				end
			end
			default: state_nxt = ST_IDLE;
		endcase
	end

	// The FIFO drops a read and a write in the same cycle, so pop yields to push
	assign pop = (state == ST_EXEC) && !push;

	// Control state and accumulator
	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= ST_IDLE;
			acc       <= '0;
			res_valid <= 1'b0;
		end else begin
			state     <= state_nxt;
			res_valid <= pop;
			if (pop) begin
				acc <= acc_nxt;
			end
		end
	end

	// Result payload, captured on the same edge as the pop
	always_ff @(posedge clk) begin
		if (pop) begin
			res_data <= acc_nxt;
			res_op   <= op;
		end
	end

	// ========================================================================
	// Assertions
	// ========================================================================

	// A push is never cancelled by a pop in the same cycle
	// So every push adds exactly one entry to the queue
	a_push_not_dropped: assert property (
		@(posedge clk) disable iff (rst)
		push |=> (occupancy == $past(occupancy) + 4'd1)
	) else $error("push did not add an entry to the queue");

	// The executor only retires an entry that the FIFOs actually hold
	a_pop_not_empty: assert property (
		@(posedge clk) disable iff (rst)
		pop |-> (occupancy != 4'd0)
	) else $error("pop raised with an empty queue");

	// Upstream must respect the full level, or the count would wrap to empty
	a_push_not_full: assert property (
		@(posedge clk) disable iff (rst)
		push |-> (occupancy != `OPQ_FULL_LEVEL)
	) else $error("push arrived at the full level");

endmodule

// File: hdl/opq_fifo.sv
module opq_fifo #(
	parameter int wid = 3
) (
	input  logic           rst,
	input  logic           clk,
	input  logic           wr,
	input  logic [wid-1:0] di,
	input  logic           rd,
	output logic [wid-1:0] dout,
	output logic [3:0]     cnt
);

	// ========================================================================
	// Storage and pointers
	// ========================================================================

	// Sixteen entries addressed by 4-bit pointers that wrap on their own
	logic [wid-1:0] mem [0:15];
	logic [3:0]     wr_ptr;
	logic [3:0]     rd_ptr;

	// Pointer and memory update
	// A write together with a read is ignored, and both pointers hold
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= 4'd0;
			rd_ptr <= 4'd0;
			for (int n = 0; n < 16; n++) begin
				mem[n] <= '0;
			end
		end else begin
			if (wr && !rd) begin
				// Lone write: store at the write pointer and step it
				mem[wr_ptr] <= di;
				wr_ptr      <= wr_ptr + 4'd1;
			end else if (rd && !wr) begin
				// Lone read: the entry is consumed by stepping the read pointer
				rd_ptr <= rd_ptr + 4'd1;
			end
		end
	end

	// ========================================================================
	// Output and count
	// ========================================================================

	// The output register follows the read pointer one edge behind it
	// A consumer must allow a cycle after a pop or a first write before using dout
	always_ff @(posedge clk) begin
		dout <= mem[rd_ptr];
	end

	// Distance from read to write pointer, modulo 16
	// Equal pointers mean empty, so at most 15 entries can be told apart
	always_comb begin
		cnt = wr_ptr - rd_ptr;
	end

endmodule

// File: hdl/opq_top.sv
`include "opq_defines.svh"

module opq_top (
	input  logic                   rst,
	input  logic                   clk,
	input  logic                   push,
	input  opq_pkg::op_e           push_op,
	input  logic [`OPQ_DATA_W-1:0] push_data,
	output logic                   full,
	output logic                   res_valid,
	output logic [`OPQ_DATA_W-1:0] res_data,
	output opq_pkg::op_e           res_op
);

	import opq_pkg::*;

	// ========================================================================
	// Queue
	// ========================================================================

	logic                   pop;
	logic [3:0]             occupancy;
	logic [$bits(op_e)-1:0] op_raw;
	op_e                    op;
	logic [`OPQ_DATA_W-1:0] data;

	// Opcode half of the queue, its count stands for both halves
	opq_fifo #(
		.wid ($bits(op_e))
	) i_op_fifo (
		.rst  (rst),
		.clk  (clk),
		.wr   (push),
		.di   (push_op),
		.rd   (pop),
		.dout (op_raw),
		.cnt  (occupancy)
	);

	// Operand half of the queue
	// It sees the same wr and rd, so its count always equals the opcode count
	opq_fifo #(
		.wid (`OPQ_DATA_W)
	) i_data_fifo (
		.rst  (rst),
		.clk  (clk),
		.wr   (push),
		.di   (push_data),
		.rd   (pop),
		.dout (data),
		.cnt  ()
	);

	// The opcode FIFO stores plain bits, the executor takes the enum
	assign op = op_e'(op_raw);

	// Upstream stops pushing while this is high
	assign full = (occupancy == `OPQ_FULL_LEVEL);

	// ========================================================================
	// Executor
	// ========================================================================

	opq_exec i_exec (
		.rst       (rst),
		.clk       (clk),
		.push      (push),
		.occupancy (occupancy),
		.op        (op),
		.data      (data),
		.pop       (pop),
		.res_valid (res_valid),
		.res_data  (res_data),
		.res_op    (res_op)
	);

endmodule

// File: tb/opq_tb.sv
`include "opq_defines.svh"

module opq_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import opq_pkg::*;

	// Clock period in ns and the length of each stimulus phase in cycles
	localparam int CLK_PERIOD = 4;
	localparam int IDLE_CYCLES = 20;
	localparam int RAND_CYCLES = 400;
	localparam int BURST_CYCLES = 200;
	localparam int DENSE_CYCLES = 300;
	localparam int DIRECTED_MAX = 40;
	// Every stimulus cycle can carry at most one push
	localparam int MAX_PUSHES = RAND_CYCLES + BURST_CYCLES + DENSE_CYCLES + DIRECTED_MAX;
	localparam int WATCHDOG_NS = MAX_PUSHES * 8 * CLK_PERIOD + 2000;

	logic                   clk;
	logic                   rst;
	logic                   push;
	op_e                    push_op;
	logic [`OPQ_DATA_W-1:0] push_data;
	logic                   full;
	logic                   res_valid;
	logic [`OPQ_DATA_W-1:0] res_data;
	op_e                    res_op;

	// Values for the next rising edge, decided at the falling edge before it
	logic                   nxt_rst;
	logic                   nxt_push;
	op_e                    nxt_op;
	logic [`OPQ_DATA_W-1:0] nxt_data;

	// Model of the queue contents and of the accumulator
	op_e                    model_ops[$];
	logic [`OPQ_DATA_W-1:0] model_data[$];
	logic [`OPQ_DATA_W-1:0] model_acc;
	// Directed entries that take precedence over random ones
	op_e                    forced_ops[$];
	logic [`OPQ_DATA_W-1:0] forced_data[$];

	logic [31:0] rng;
	int          taken;
	int          results;
	int          full_seen;
	int          value_errors;
	int          other_errors;

	opq_top i_opq_top (
		.rst       (rst),
		.clk       (clk),
		.push      (push),
		.push_op   (push_op),
		.push_data (push_data),
		.full      (full),
		.res_valid (res_valid),
		.res_data  (res_data),
		.res_op    (res_op)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	// ========================================================================
	// Model and helpers
	// ========================================================================

	// Linear congruential generator, upper bits are the useful ones
	function automatic logic [31:0] next_random();
		rng = rng * 32'd1664525 + 32'd1013904223;
		return rng;
	endfunction

	// Accumulator rule for one operation, wrapping at the data width
	function automatic logic [`OPQ_DATA_W-1:0] apply_op(
		input op_e                    f_op,
		input logic [`OPQ_DATA_W-1:0] f_acc,
		input logic [`OPQ_DATA_W-1:0] f_val
	);
		case (f_op)
			OP_LOAD: return f_val;
			OP_ADD:  return f_acc + f_val;
			OP_SUB:  return f_acc - f_val;
			OP_AND:  return f_acc & f_val;
			OP_OR:   return f_acc | f_val;
			OP_XOR:  return f_acc ^ f_val;
			OP_NEG:  return 8'd0 - f_acc;
			default: return f_acc;
		endcase
	endfunction

	task automatic check_op(input string name, input op_e exp, input op_e act);
		if (exp !== act) begin
			value_errors++;
			$display("CHECK FAILED at %0t: %s expected %s got %s", $time, name,
				exp.name(), act.name());
		end
	endtask

	task automatic check_data(
		input string                  name,
		input logic [`OPQ_DATA_W-1:0] exp,
		input logic [`OPQ_DATA_W-1:0] act
	);
		if (exp !== act) begin
			value_errors++;
			$display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			value_errors++;
			$display("CHECK FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	// Falling edge checks, outputs are settled here
	// Results seen so far match the pops done up to the last edge, so the
	// difference to accepted pushes is the true occupancy
	task automatic observe();
		op_e exp_op;
		if (rst) begin
			check_flag("res_valid", 1'b0, res_valid);
		end else if (res_valid) begin
			if (model_ops.size() == 0) begin
				other_errors++;
				$display("Error at %0t: result came out with no entry in the model queue",
					$time);
			end else begin
				exp_op = model_ops.pop_front();
				model_acc = apply_op(exp_op, model_acc, model_data.pop_front());
				check_op("res_op", exp_op, res_op);
				check_data("res_data", model_acc, res_data);
			end
			results++;
		end
		check_flag("full", (taken - results) == 15, full);
		if (full) begin
			full_seen++;
		end
	endtask

	// One clock cycle: apply the decided inputs, observe, then decide anew
	// A push is allowed only if the queue cannot reach the full level with it
	task automatic step(input int pct);
		logic [31:0] r;
		logic        allowed;
		logic        go;
		@(posedge clk);
		if (push) begin
			model_ops.push_back(push_op);
			model_data.push_back(push_data);
			taken++;
		end
		rst       <= nxt_rst;
		push      <= nxt_push;
		push_op   <= nxt_op;
		push_data <= nxt_data;
		@(negedge clk);
		observe();
		allowed = !rst && (taken - results + int'(push)) < 15;
		r = next_random();
		if (forced_ops.size() > 0) begin
			go = allowed;
		end else begin
			go = allowed && (int'(r[31:16]) % 100) < pct;
		end
		nxt_push = go;
		if (go && forced_ops.size() > 0) begin
			nxt_op   = forced_ops.pop_front();
			nxt_data = forced_data.pop_front();
		end else begin
			r = next_random();
			nxt_op   = op_e'(r[31:29]);
			nxt_data = r[23:16];
		end
	endtask

	// ========================================================================
	// Stimulus
	// ========================================================================

	initial begin
		rst = 1'b1;
		push = 1'b0;
		push_op = OP_NOP;
		push_data = '0;
		nxt_rst = 1'b1;
		nxt_push = 1'b0;
		nxt_op = OP_NOP;
		nxt_data = '0;
		rng = 32'hb46f_43be;
		model_acc = '0;
		taken = 0;
		results = 0;
		full_seen = 0;
		value_errors = 0;
		other_errors = 0;

		// Reset for 16 edges, then a quiet stretch with no results
		for (int i = 0; i < 16; i++) begin
			if (i == 15) begin
				nxt_rst = 1'b0;
			end
			step(0);
		end
		for (int i = 0; i < IDLE_CYCLES; i++) begin
			check_flag("res_valid", 1'b0, res_valid);
			step(0);
		end

		// LOAD then NEG, with NOPs that must repeat the accumulator
		forced_ops = '{OP_LOAD, OP_NOP, OP_NEG, OP_NOP, OP_LOAD, OP_NEG, OP_NOP};
		forced_data = '{8'h5a, 8'hff, 8'h33, 8'h00, 8'h01, 8'h80, 8'h7e};
		while (forced_ops.size() > 0) begin
			step(0);
		end

		// Random mix, then a burst that fills the queue, then dense traffic
		repeat (RAND_CYCLES) step(45);
		full_seen = 0;
		repeat (BURST_CYCLES) step(100);
		if (full_seen == 0) begin
			other_errors++;
			$display("Error at %0t: full never rose during the burst phase", $time);
		end
		repeat (DENSE_CYCLES) step(85);

		// Drain everything that is still queued, then look for stray results
		while ((taken - results + int'(push)) > 0) begin
			step(0);
		end
		repeat (20) step(0);

		if (model_ops.size() != 0) begin
			other_errors++;
			$display("Error: %0d entries were pushed but never came out", model_ops.size());
		end
		if (taken != results) begin
			other_errors++;
			$display("Error: %0d pushes accepted but %0d results seen", taken, results);
		end

		$display("Pushes %0d, results %0d, value errors %0d, other errors %0d",
			taken, results, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// Watchdog sized for the longest possible run
	initial begin
		#(WATCHDOG_NS * 1ns);
		$display("Error: run did not finish within %0d ns", WATCHDOG_NS);
		$display("Pushes %0d, results %0d, value errors %0d, other errors %0d",
			taken, results, value_errors, other_errors + 1);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule
